// File: Makefile
# Verilator build and run for the background renderer

VERILATOR ?= verilator
TOP       ?= ppu_bg_render_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
ppu_timing_pkg.sv
ppu_reg_pkg.sv
ppu_scan_if.sv
ppu_scan_timer.sv
ppu_bg_fetch.sv
ppu_vbuf_writer.sv
ppu_bg_render.sv
ppu_bg_render_checker.sv
ppu_bg_render_tb.sv

// File: ppu_bg_fetch.sv
`timescale 1ns/10ps

module ppu_bg_fetch (
    input  logic                              i_clk,
    input  logic                              i_rstn,
    ppu_scan_if.fetch                         scan,
    input  logic [5:0]                        i_ppuctrl,
    input  logic [7:0]                        i_ppumask,
    input  logic [7:0]                        i_scroll_x,
    input  logic [7:0]                        i_scroll_y,
    output logic [ppu_reg_pkg::NT_AW-1:0]     o_nt_addr,
    input  ppu_reg_pkg::nt_word_u             i_nt_rdata,
    output logic [ppu_reg_pkg::PT_AW-1:0]     o_pt_addr,
    input  logic [15:0]                       i_pt_rdata,
    output logic [ppu_reg_pkg::PLT_AW-1:0]    o_plt_addr
);

    logic [1:0]  c_nt_sel;   // base select from ctrl
    logic [4:0]  r_ntx;      // coarse x
    logic [2:0]  r_finex;
    logic [4:0]  r_nty;      // coarse y
    logic [2:0]  r_finey;
    logic [1:0]  r_nt_base;  // {vertical, horizontal} nametable
    logic [2:0]  c_phase;    // position in 8-cycle tile group
    logic [9:0]  c_attr_addr;
    logic [1:0]  c_attr_q;
    logic [15:0] r_pt_hi;    // plane 1 shifter
    logic [15:0] r_pt_lo;    // plane 0 shifter
    logic [15:0] r_at_hi;
    logic [15:0] r_at_lo;
    logic [3:0]  c_bit_sel;
    logic [3:0]  c_bg_pix;
    logic        c_blank;

    assign c_nt_sel = i_ppuctrl[ppu_reg_pkg::CTRL_NT_BASE_LSB +: 2];
    assign c_phase  = scan.scan_x[2:0];

    ////////////////////////////////////////
    // scroll counters
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_ntx     <= '0;
            r_finex   <= '0;
            r_nty     <= '0;
            r_finey   <= '0;
            r_nt_base <= '0;
        end else begin
            // vertical part
            if (scan.scan_y == ppu_timing_pkg::SCAN_Y_LAST &&
                scan.scan_x == ppu_timing_pkg::RELOAD_Y_X) begin
                r_nty        <= i_scroll_y[7:3];
                r_finey      <= i_scroll_y[2:0];
                r_nt_base[1] <= c_nt_sel[1];
            end else if (scan.scan_x == ppu_timing_pkg::INC_Y_X) begin
                r_finey <= r_finey + 3'd1;
                if (r_finey == 3'd7) begin
                    if (r_nty == ppu_reg_pkg::NT_ROWS - 5'd1) begin
                        r_nty        <= '0;
                        r_nt_base[1] <= ~r_nt_base[1]; // next nametable down
                    end else begin
                        r_nty <= r_nty + 5'd1;
                    end
                end
            end

            // horizontal part
            if (scan.scan_x == ppu_timing_pkg::RELOAD_X) begin
                r_ntx        <= i_scroll_x[7:3];
                r_finex      <= i_scroll_x[2:0];
                r_nt_base[0] <= c_nt_sel[0];
            end else if (scan.pixel_calc && c_phase == ppu_timing_pkg::FETCH_LOAD) begin
                r_ntx <= r_ntx + 5'd1; // wraps 31 -> 0
                if (r_ntx == 5'd31)
                    r_nt_base[0] <= ~r_nt_base[0];
            end
        end
    end

    ////////////////////////////////////////
    // fetch addresses
    ////////////////////////////////////////
    // one attribute byte per 4x4 tiles
    assign c_attr_addr = ppu_reg_pkg::ATTR_BASE + {4'b0000, r_nty[4:2], r_ntx[4:2]};

    always_comb begin
        o_nt_addr = {r_nt_base, 10'h000};
        if (scan.pixel_calc) begin
            if (c_phase == ppu_timing_pkg::FETCH_NT)
                o_nt_addr[9:0] = {r_nty, r_ntx}; // tile index
            else if (c_phase == ppu_timing_pkg::FETCH_AT)
                o_nt_addr[9:0] = c_attr_addr;
        end
    end

    // tile index is back on the attribute cycle
    always_comb begin
        o_pt_addr = '0;
        if (scan.pixel_calc && c_phase == ppu_timing_pkg::FETCH_AT)
            o_pt_addr = {i_ppuctrl[ppu_reg_pkg::CTRL_BG_PT_SEL], i_nt_rdata.tile, r_finey};
    end

    // attribute word back on load cycle
    assign c_attr_q = i_nt_rdata.attr_q[{r_nty[1], r_ntx[1]}];

    ////////////////////////////////////////
    // tile shifters
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_pt_hi <= '0;
            r_pt_lo <= '0;
            r_at_hi <= '0;
            r_at_lo <= '0;
        end else if (scan.pixel_calc) begin
            if (c_phase == ppu_timing_pkg::FETCH_LOAD) begin
                // upper half keeps shifting, new tile enters below
                r_pt_hi <= {r_pt_hi[14:7], i_pt_rdata[15:8]};
                r_pt_lo <= {r_pt_lo[14:7], i_pt_rdata[7:0]};
                r_at_hi <= {r_at_hi[14:7], {8{c_attr_q[1]}}};
                r_at_lo <= {r_at_lo[14:7], {8{c_attr_q[0]}}};
            end else begin
                r_pt_hi <= {r_pt_hi[14:0], 1'b0};
                r_pt_lo <= {r_pt_lo[14:0], 1'b0};
                r_at_hi <= {r_at_hi[14:0], 1'b0};
                r_at_lo <= {r_at_lo[14:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////
    // pixel select + palette address
    ////////////////////////////////////////
    assign c_bit_sel = 4'd15 - {1'b0, r_finex}; // fine x picks the column
    assign c_bg_pix  = {r_at_hi[c_bit_sel], r_at_lo[c_bit_sel],
                        r_pt_hi[c_bit_sel], r_pt_lo[c_bit_sel]};

    // bg off, or left columns hidden
    assign c_blank = ~i_ppumask[ppu_reg_pkg::MASK_BG_ENA] |
                     (~i_ppumask[ppu_reg_pkg::MASK_BG_CLIP] &
                      (scan.scan_x < ppu_timing_pkg::CLIP_COLS));

    assign o_plt_addr = c_blank ? '0 : {1'b0, c_bg_pix}; // bg palettes only

endmodule

// File: ppu_bg_render.sv
`timescale 1ns/10ps

module ppu_bg_render (
    input  logic                               i_clk,
    input  logic                               i_rstn,
    input  logic [5:0]                         i_ppuctrl,
    input  logic [7:0]                         i_ppumask,
    input  logic [7:0]                         i_scroll_x,
    input  logic [7:0]                         i_scroll_y,
    input  logic                               i_vblank,
    output logic                               o_rde_run,
    // video memories
    output logic [ppu_reg_pkg::NT_AW-1:0]      o_nt_addr,
    input  logic [7:0]                         i_nt_rdata,
    output logic [ppu_reg_pkg::PT_AW-1:0]      o_pt_addr,
    input  logic [15:0]                        i_pt_rdata,
    output logic [ppu_reg_pkg::PLT_AW-1:0]     o_plt_addr,
    input  logic [7:0]                         i_plt_rdata,
    // frame buffer
    output logic [ppu_reg_pkg::VBUF_AW-1:0]    o_vbuf_addr,
    output logic                               o_vbuf_we,
    output logic [7:0]                         o_vbuf_wdata
);

    ppu_reg_pkg::nt_word_u c_nt_word; // raw byte seen as the union

    ppu_scan_if scan_if ();

    assign c_nt_word = i_nt_rdata;
    assign o_rde_run = scan_if.run;

    ////////////////////////////////////////
    // scan timing
    ppu_scan_timer u_scan_timer (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_vblank  (i_vblank),
        .scan      (scan_if.timer)
    );

    ////////////////////////////////////////
    // background fetch and pixel
    ppu_bg_fetch u_bg_fetch (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .scan       (scan_if.fetch),
        .i_ppuctrl  (i_ppuctrl),
        .i_ppumask  (i_ppumask),
        .i_scroll_x (i_scroll_x),
        .i_scroll_y (i_scroll_y),
        .o_nt_addr  (o_nt_addr),
        .i_nt_rdata (c_nt_word),
        .o_pt_addr  (o_pt_addr),
        .i_pt_rdata (i_pt_rdata),
        .o_plt_addr (o_plt_addr)
    );

    ////////////////////////////////////////
    // frame buffer writes
    ppu_vbuf_writer u_vbuf_writer (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .scan         (scan_if.writer),
        .i_plt_rdata  (i_plt_rdata),
        .o_vbuf_addr  (o_vbuf_addr),
        .o_vbuf_we    (o_vbuf_we),
        .o_vbuf_wdata (o_vbuf_wdata)
    );

endmodule

// File: ppu_bg_render_checker.sv
`timescale 1ns/10ps

module ppu_bg_render_checker (
    input  logic                            i_clk,
    input  logic                            i_rstn,
    input  logic                            i_run,
    input  logic                            i_vbuf_we,
    input  logic [ppu_reg_pkg::VBUF_AW-1:0] i_vbuf_addr,
    input  logic [ppu_reg_pkg::PLT_AW-1:0]  i_plt_addr
);

    ////////////////////////////////////////
    // frame buffer write rules
    ////////////////////////////////////////
    a_we_after_run: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_vbuf_we |-> $past(i_run)) // writer sees run one cycle late
        else $error("frame buffer write without run on the previous cycle");

    // x field steps by one along a line
    a_x_step: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_vbuf_we && $past(i_vbuf_we) && i_vbuf_addr[16:8] == $past(i_vbuf_addr[16:8]))
        |-> (i_vbuf_addr[7:0] == $past(i_vbuf_addr[7:0]) + 8'd1))
        else $error("frame buffer x address did not step by one within a line");

    a_bg_palette: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !i_plt_addr[4]) // upper half belongs to sprites
        else $error("palette address points into the sprite half");

endmodule

bind ppu_bg_render ppu_bg_render_checker checker_i (
    .i_clk       (i_clk),
    .i_rstn      (i_rstn),
    .i_run       (o_rde_run),
    .i_vbuf_we   (o_vbuf_we),
    .i_vbuf_addr (o_vbuf_addr),
    .i_plt_addr  (o_plt_addr)
);

// File: ppu_bg_render_tb.sv
`timescale 1ns/10ps

module ppu_bg_render_tb;

    logic        i_clk = 1'b0;
    logic        i_rstn;
    logic [5:0]  i_ppuctrl;
    logic [7:0]  i_ppumask;
    logic [7:0]  i_scroll_x;
    logic [7:0]  i_scroll_y;
    logic        i_vblank;
    logic        o_rde_run;
    logic [11:0] o_nt_addr;
    logic [7:0]  i_nt_rdata = '0;  // driven by the memory models
    logic [11:0] o_pt_addr;
    logic [15:0] i_pt_rdata = '0;
    logic [4:0]  o_plt_addr;
    logic [7:0]  i_plt_rdata = '0;
    logic [16:0] o_vbuf_addr;
    logic        o_vbuf_we;
    logic [7:0]  o_vbuf_wdata;

    logic [7:0]  nt_mem [0:4095];   // four nametables
    logic [15:0] pt_mem [0:4095];   // {plane 1, plane 0}
    logic [7:0]  plt_mem [0:31];
    logic [11:0] nt_addr_s;
    logic [11:0] pt_addr_s;
    logic [4:0]  plt_addr_s;
    logic [7:0]  shadow_mem [0:131071]; // frame buffer copy
    int          wr_count [0:131071];
    int          wr_frame [0:131071];   // frame that last wrote here
    int          frame_writes [0:15];
    bit          page_seen [0:15];
    bit          page_of [0:15];
    bit          page_mixed [0:15];
    logic [3:0]  frame_id;              // 0 = before first frame
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    ppu_bg_render dut_i (.*);

    always #50 i_clk = ~i_clk; // 100 ns

    ////////////////////////////////////////
    // synchronous read memories
    ////////////////////////////////////////
    // addresses taken mid cycle
    always @(negedge i_clk) begin
        nt_addr_s  = o_nt_addr;
        pt_addr_s  = o_pt_addr;
        plt_addr_s = o_plt_addr;
    end

    // data of the cycle just ended
    always @(posedge i_clk) begin
        #1;
        i_nt_rdata  = nt_mem[nt_addr_s];
        i_pt_rdata  = pt_mem[pt_addr_s];
        i_plt_rdata = plt_mem[plt_addr_s];
    end

    // frame capture, mid cycle
    always @(negedge i_clk) begin
        if (o_vbuf_we === 1'b1) begin
            shadow_mem[o_vbuf_addr] = o_vbuf_wdata;
            if (wr_frame[o_vbuf_addr] != int'(frame_id)) begin
                wr_frame[o_vbuf_addr] = int'(frame_id);
                wr_count[o_vbuf_addr] = 1;
            end else begin
                wr_count[o_vbuf_addr] = wr_count[o_vbuf_addr] + 1;
            end
            frame_writes[frame_id] = frame_writes[frame_id] + 1;
            if (!page_seen[frame_id]) begin
                page_seen[frame_id] = 1'b1;
                page_of[frame_id]   = o_vbuf_addr[16];
            end else if (o_vbuf_addr[16] !== page_of[frame_id]) begin
                page_mixed[frame_id] = 1'b1;
            end
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic fill_memories();
        logic [15:0] v;
        for (int a = 0; a < 4096; a++) begin
            v = rand_bits(8);
            nt_mem[12'(a)] = v[7:0];
            pt_mem[12'(a)] = rand_bits(16);
        end
        for (int a = 0; a < 32; a++) begin
            v = rand_bits(3);
            plt_mem[5'(a)] = {5'(a), v[2:0]}; // every entry distinct
        end
    endtask

    ////////////////////////////////////////
    // reference pixel from world coordinates
    ////////////////////////////////////////
    function automatic logic [7:0] ref_pixel(input int x, input int y);
        int          wx;
        int          wy;
        int          nt_sel;
        int          row;
        int          col;
        logic [7:0]  tile;
        logic [7:0]  attr;
        logic [7:0]  quad;
        logic [15:0] pw;
        logic [7:0]  p1;
        logic [7:0]  p0;
        if (!i_ppumask[ppu_reg_pkg::MASK_BG_ENA])
            return plt_mem[5'd0];
        if (!i_ppumask[ppu_reg_pkg::MASK_BG_CLIP] && x < int'(ppu_timing_pkg::CLIP_COLS))
            return plt_mem[5'd0];
        nt_sel = int'(i_ppuctrl[ppu_reg_pkg::CTRL_NT_BASE_LSB +: 2]);
        wx = int'(i_scroll_x) + x;
        if (wx >= 256) begin
            wx = wx - 256;
            nt_sel = nt_sel ^ 1; // right neighbour
        end
        wy = int'(i_scroll_y) + y;
        if (wy >= 240) begin
            wy = wy - 240;
            nt_sel = nt_sel ^ 2; // neighbour below
        end
        row  = wy / 8;
        col  = wx / 8;
        tile = nt_mem[{2'(nt_sel), 5'(row), 5'(col)}];
        attr = nt_mem[{2'(nt_sel), ppu_reg_pkg::ATTR_BASE + 10'((row / 4) * 8 + col / 4)}];
        quad = attr >> (2 * (((row / 2) % 2) * 2 + (col / 2) % 2));
        pw   = pt_mem[{i_ppuctrl[ppu_reg_pkg::CTRL_BG_PT_SEL], tile, 3'(wy % 8)}];
        p1   = pw[15:8] >> (7 - wx % 8);
        p0   = pw[7:0] >> (7 - wx % 8);
        return plt_mem[{1'b0, quad[1:0], p1[0], p0[0]}];
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic compare_int(input string sig, input int exp, input int got);
        checks = checks + 1;
        assert (got == exp) else begin
            errors = errors + 1;
            $display("[ERROR] %0d ns %s expected %0d got %0d", $time, sig, exp, got);
        end
    endtask

    task automatic wait_run(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (o_rde_run !== level && cycles < limit) begin
            @(negedge i_clk);
            cycles = cycles + 1;
        end
        if (o_rde_run !== level) begin
            errors = errors + 1;
            $display("timeout, o_rde_run did not reach %0b in %0d cycles", level, limit);
            finish_run();
        end
    endtask

    task automatic set_config(input logic [5:0] ctrl, input logic [7:0] mask,
                              input logic [7:0] sx, input logic [7:0] sy);
        @(posedge i_clk);
        #1;
        i_ppuctrl  = ctrl;
        i_ppumask  = mask;
        i_scroll_x = sx;
        i_scroll_y = sy;
    endtask

    // vblank pulse, then one whole frame
    task automatic run_frame();
        int n;
        frame_id = frame_id + 4'd1;
        @(posedge i_clk);
        #1;
        i_vblank = 1'b1;
        wait_run(1'b1, 20, n);
        // frame_start 2 cycles after vblank, run one later, vblank cycle counted
        compare_int("o_rde_run rise delay", 4, n);
        @(posedge i_clk);
        #1;
        i_vblank = 1'b0;
        wait_run(1'b0, 90000, n);
        compare_int("o_rde_run high cycles", 262 * 320, n);
        repeat (4) @(posedge i_clk);
    endtask

    task automatic check_frame_writes();
        logic [16:0] va;
        int          cnt;
        compare_int("frame buffer writes",
                    int'(ppu_timing_pkg::SCAN_Y_VIS) * int'(ppu_timing_pkg::PIX_VIS),
                    frame_writes[frame_id]);
        checks = checks + 1;
        assert (!page_mixed[frame_id]) else begin
            errors = errors + 1;
            $display("page bit changed inside frame %0d", frame_id);
        end
        for (int y = 0; y < int'(ppu_timing_pkg::SCAN_Y_VIS); y++) begin
            for (int x = 0; x < int'(ppu_timing_pkg::PIX_VIS); x++) begin
                va  = {page_of[frame_id], y[7:0], x[7:0]};
                cnt = (wr_frame[va] == int'(frame_id)) ? wr_count[va] : 0;
                checks = checks + 1;
                assert (cnt == 1) else begin
                    errors = errors + 1;
                    $display("[ERROR] %0d ns writes to o_vbuf_addr %05h expected 1 got %0d",
                             $time, va, cnt);
                end
            end
        end
    endtask

    task automatic check_pixels();
        logic [16:0] va;
        logic [7:0]  exp;
        for (int y = 0; y < int'(ppu_timing_pkg::SCAN_Y_VIS); y++) begin
            for (int x = 0; x < int'(ppu_timing_pkg::PIX_VIS); x++) begin
                va  = {page_of[frame_id], y[7:0], x[7:0]};
                exp = ref_pixel(x, y);
                checks = checks + 1;
                assert (shadow_mem[va] === exp) else begin
                    errors = errors + 1;
                    $display("[ERROR] %0d ns o_vbuf_wdata x=%0d y=%0d expected %02h got %02h",
                             $time, x, y, exp, shadow_mem[va]);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_idle_after_reset();
        for (int i = 0; i < 2000; i++) begin
            @(negedge i_clk);
            checks = checks + 1;
            assert (o_rde_run === 1'b0 && o_vbuf_we === 1'b0) else begin
                errors = errors + 1;
                $display("[ERROR] %0d ns o_rde_run/o_vbuf_we expected 0/0 got %b/%b",
                         $time, o_rde_run, o_vbuf_we);
            end
        end
        compare_int("writes before first vblank", 0, frame_writes[0]);
    endtask

    task automatic test_frame_coverage();
        set_config(6'h00, 8'h0A, 8'h00, 8'h00);
        run_frame();
        check_frame_writes();
    endtask

    task automatic test_page_toggle();
        logic [2:0] pages;
        pages = '0;
        repeat (3) begin
            run_frame();
            check_frame_writes();
            pages = {pages[1:0], page_of[frame_id]}; // oldest ends in bit 2
        end
        compare_int("page bit of second frame", pages[2] ? 0 : 1, int'(pages[1]));
        compare_int("page bit of third frame", pages[1] ? 0 : 1, int'(pages[0]));
    endtask

    task automatic test_pixels_no_scroll();
        set_config(6'h00, 8'h0A, 8'h00, 8'h00);
        run_frame();
        check_pixels();
    endtask

    // coarse 20 fine 5 in x, coarse 25 fine 3 in y, base 3
    task automatic test_pixels_scrolled();
        set_config(6'h13, 8'h0A, 8'hA5, 8'hCB);
        run_frame();
        check_frame_writes();
        check_pixels();
    endtask

    task automatic test_clip_and_disable();
        set_config(6'h01, 8'h08, 8'h3C, 8'h51); // left columns hidden
        run_frame();
        check_pixels();
        set_config(6'h12, 8'h00, 8'h11, 8'h22); // background off
        run_frame();
        check_pixels();
    endtask

    initial begin
        i_rstn     = 1'b0;
        i_ppuctrl  = '0;
        i_ppumask  = '0;
        i_scroll_x = '0;
        i_scroll_y = '0;
        i_vblank   = 1'b0;
        frame_id   = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h22af_4341;
        fill_memories();
        repeat (10) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;

        test_idle_after_reset();
        test_frame_coverage();
        test_page_toggle();
        test_pixels_no_scroll();
        test_pixels_scrolled();
        test_clip_and_disable();
        finish_run();
    end

endmodule

// File: ppu_reg_pkg.sv
package ppu_reg_pkg;

    ////////////////////////////////////////
    // control and mask word fields
    ////////////////////////////////////////
    localparam int CTRL_BG_PT_SEL   = 4; // background pattern table half
    localparam int CTRL_NT_BASE_LSB = 0; // two-bit nametable select starts here
    localparam int MASK_BG_ENA      = 3; // background on
    localparam int MASK_BG_CLIP     = 1; // 1 shows the left 8 columns

    // nametable layout
    localparam logic [4:0] NT_ROWS   = 5'd30;   // tile rows per nametable
    localparam logic [9:0] ATTR_BASE = 10'h3C0; // attribute block offset

    ////////////////////////////////////////
    // memory address widths
    ////////////////////////////////////////
    localparam int PT_AW   = 12; // pattern table
    localparam int NT_AW   = 12; // four nametables
    localparam int PLT_AW  = 5;  // palette
    localparam int VBUF_AW = 17; // page + y + x

    // one nametable read word, two meanings
    // tile index on the first fetch cycle, attribute byte on the next
    typedef union packed {
        logic [7:0]      tile;   // tile index
        logic [3:0][1:0] attr_q; // quadrant q = {row[1], col[1]}
    } nt_word_u;

endpackage

// File: ppu_scan_if.sv
`timescale 1ns/10ps

interface ppu_scan_if;

    logic [8:0] scan_x;      // cycle within line
    logic [8:0] scan_y;      // line within frame
    logic       pixel_calc;  // rendered line and pixel/prefetch slot
    logic       frame_start; // one cycle at vblank rise
    logic       run;         // frame in progress

    // timer owns everything
    modport timer  (output scan_x, scan_y, pixel_calc, frame_start, run);

    // background fetch side
    modport fetch  (input scan_x, scan_y, pixel_calc);

    // frame buffer side
    modport writer (input scan_x, scan_y, frame_start, run);

endinterface

// File: ppu_scan_timer.sv
`timescale 1ns/10ps

module ppu_scan_timer (
    input  logic       i_clk,
    input  logic       i_rstn,
    input  logic       i_vblank,
    ppu_scan_if.timer  scan
);

    logic       r_vblank;   // sync stage 1
    logic       rr_vblank;  // sync stage 2
    logic       rrr_vblank; // synced value one cycle back
    logic       c_frame_start;
    logic       r_run;
    logic [8:0] r_scan_x;
    logic [8:0] r_scan_y;
    logic       c_line_rde; // rendered line
    logic       c_slot_rde; // pixel or prefetch cycle

    // vblank sync + rise detect
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_vblank   <= 1'b0;
            rr_vblank  <= 1'b0;
            rrr_vblank <= 1'b0;
        end else begin
            r_vblank   <= i_vblank;
            rr_vblank  <= r_vblank;
            rrr_vblank <= rr_vblank;
        end
    end

    assign c_frame_start = rr_vblank & ~rrr_vblank; // rise of the synced vblank

    // run flag, one frame per vblank
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_run <= 1'b0;
        end else if (c_frame_start) begin
            r_run <= 1'b1;
        end else if (r_scan_y == ppu_timing_pkg::SCAN_Y_VIS - 9'd1 &&
                     r_scan_x == ppu_timing_pkg::SCAN_X_MAX) begin
            r_run <= 1'b0; // last visible line done
        end
    end

    ////////////////////////////////////////
    // line and pixel counters
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_scan_x <= '0;
            r_scan_y <= '0;
        end else if (c_frame_start) begin
            r_scan_x <= '0;
            r_scan_y <= ppu_timing_pkg::SCAN_Y_VBL_START; // frame opens in vblank
        end else if (r_run) begin
            if (r_scan_x == ppu_timing_pkg::SCAN_X_MAX) begin
                r_scan_x <= '0;
                if (r_scan_y == ppu_timing_pkg::SCAN_Y_LAST)
                    r_scan_y <= '0;
                else
                    r_scan_y <= r_scan_y + 9'd1;
            end else begin
                r_scan_x <= r_scan_x + 9'd1;
            end
        end
    end

    // lines 0-239 and pre-render, cycles 0-255 and 272-287
    assign c_line_rde = (r_scan_y < ppu_timing_pkg::SCAN_Y_VIS) |
                        (r_scan_y == ppu_timing_pkg::SCAN_Y_LAST);
    assign c_slot_rde = (r_scan_x < ppu_timing_pkg::PIX_VIS) |
                        ((r_scan_x >= ppu_timing_pkg::PREFETCH_X) &&
                         (r_scan_x <  ppu_timing_pkg::PREFETCH_X + 9'd16));

    assign scan.scan_x      = r_scan_x;
    assign scan.scan_y      = r_scan_y;
    assign scan.pixel_calc  = c_line_rde & c_slot_rde;
    assign scan.frame_start = c_frame_start;
    assign scan.run         = r_run;

endmodule

// File: ppu_timing_pkg.sv
package ppu_timing_pkg;

    ////////////////////////////////////////
    // scan geometry
    ////////////////////////////////////////
    localparam logic [8:0] SCAN_X_MAX       = 9'd319; // last cycle of a line
    localparam logic [8:0] SCAN_Y_LAST      = 9'd261; // pre-render line
    localparam logic [8:0] SCAN_Y_VIS       = 9'd240; // visible lines
    localparam logic [8:0] SCAN_Y_VBL_START = 9'd240; // line loaded at frame start
    localparam logic [8:0] PIX_VIS          = 9'd256; // visible pixels per line

    ////////////////////////////////////////
    // fetch cycle positions
    ////////////////////////////////////////
    localparam logic [8:0] PREFETCH_X = 9'd272; // two-tile prefetch window start
    localparam logic [8:0] RELOAD_X   = 9'd257; // horizontal scroll reload
    localparam logic [8:0] RELOAD_Y_X = 9'd271; // vertical reload, line 261 only
    localparam logic [8:0] INC_Y_X    = 9'd256; // fine y step
    localparam logic [2:0] FETCH_NT   = 3'd5;   // tile index address
    localparam logic [2:0] FETCH_AT   = 3'd6;   // attribute + pattern address
    localparam logic [2:0] FETCH_LOAD = 3'd7;   // shifter load
    localparam logic [8:0] CLIP_COLS  = 9'd8;   // left columns blanked by clip

endpackage

// File: ppu_vbuf_writer.sv
`timescale 1ns/10ps

module ppu_vbuf_writer (
    input  logic        i_clk,
    input  logic        i_rstn,
    ppu_scan_if.writer  scan,
    input  logic [7:0]  i_plt_rdata,
    output logic [16:0] o_vbuf_addr,
    output logic        o_vbuf_we,
    output logic [7:0]  o_vbuf_wdata
);

    logic [8:0] r_scan_x; // pixel whose palette byte is back
    logic [8:0] r_scan_y;
    logic       r_run;    // run one cycle late
    logic       r_page;   // frame buffer half being written

    // scan position follows the palette read by one cycle
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_scan_x <= '0;
            r_scan_y <= '0;
            r_run    <= 1'b0;
        end else begin
            r_scan_x <= scan.scan_x;
            r_scan_y <= scan.scan_y;
            r_run    <= scan.run;
        end
    end

    // new page each frame
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_page <= 1'b0;
        end else if (scan.frame_start) begin
            r_page <= ~r_page;
        end
    end

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    assign o_vbuf_we    = r_run &
                          (r_scan_y < ppu_timing_pkg::SCAN_Y_VIS) &
                          (r_scan_x < ppu_timing_pkg::PIX_VIS); // visible area only
    assign o_vbuf_addr  = {r_page, r_scan_y[7:0], r_scan_x[7:0]};
    assign o_vbuf_wdata = i_plt_rdata; // palette byte lands this cycle

endmodule
